//--- project.f
hw/timer_pkg.sv
hw/wb_if.sv
hw/timer_assertions.sv
hw/timer.sv
hw/irq_combiner.sv
hw/timer_subsys.sv
dv/tb_timer_subsys.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_timer_subsys
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/tb_timer_subsys.sv
// Directed testbench; a cycle model checks every output at each falling edge, runs ~1.1M cycles
`timescale 1ns/1ns

module tb_timer_subsys;

  logic                           CLK_I;
  logic                           RST_I;
  logic [31:2]                    ADR_I;
  logic                           CYC_I;
  logic                           STB_I;
  logic                           WE_I;
  logic [timer_pkg::DAT_W-1:0]    DAT_O;
  logic                           ACK_O;
  logic                           RTY_O;
  logic                           irq_o;

  // Reference model of both timers and the status port
  logic [timer_pkg::CNT_W-1:0]    m_cnt [timer_pkg::N_TIMERS];
  logic [timer_pkg::N_TIMERS-1:0] m_irq;
  logic [timer_pkg::N_TIMERS-1:0] m_rty;
  logic [timer_pkg::N_TIMERS-1:0] m_pend;
  logic                           m_ack;
  logic [timer_pkg::DAT_W-1:0]    cycle;
  string                          test_name;

  timer_subsys UUT (.*);

  always #50 CLK_I = ~CLK_I;

  function automatic logic [timer_pkg::CNT_W-1:0] term_of(input int i);
    return (i == 0) ? timer_pkg::TERM0 : timer_pkg::TERM1;
  endfunction

  function automatic logic [timer_pkg::ADR_W-1:0] ack_addr_of(input int i);
    return (i == 0) ? timer_pkg::ACK_ADDR0 : timer_pkg::ACK_ADDR1;
  endfunction

  function automatic logic [timer_pkg::DAT_W-1:0] status_word(
    input logic [timer_pkg::N_TIMERS-1:0] bits);
    return {{(timer_pkg::DAT_W - timer_pkg::N_TIMERS){1'b0}}, bits};
  endfunction

  function automatic logic [timer_pkg::DAT_W-1:0] count_word(
    input logic [timer_pkg::CNT_W-1:0] c);
    return {{(timer_pkg::DAT_W - timer_pkg::CNT_W){1'b0}}, c};
  endfunction

  // Cycle 1 is the first edge after reset release
  always @(posedge CLK_I) begin : ref_model
    logic req;
    logic hit;
    req = CYC_I && STB_I && !WE_I;
    cycle <= RST_I ? '0 : cycle + 32'd1;
    for (int i = 0; i < timer_pkg::N_TIMERS; i++) begin
      hit = req && (ADR_I == ack_addr_of(i)) && (m_cnt[i] == term_of(i)) && m_irq[i];
      if (RST_I) begin
        m_cnt[i] <= '0;
        m_irq[i] <= 1'b0;
        m_rty[i] <= 1'b0;
      end else begin
        m_rty[i] <= hit;
        if (hit) begin
          m_cnt[i] <= '0;
          m_irq[i] <= 1'b0;
        end else if (m_cnt[i] == term_of(i)) begin
          m_irq[i] <= 1'b1;
        end else begin
          m_cnt[i] <= m_cnt[i] + timer_pkg::CNT_W'(1);
        end
      end
    end
    if (RST_I) begin
      m_ack  <= 1'b0;
      m_pend <= '0;
    end else begin
      m_ack <= req && (ADR_I == timer_pkg::STAT_ADDR) && !m_ack;
      if (req && (ADR_I == timer_pkg::STAT_ADDR) && !m_ack) begin
        m_pend <= m_irq;
      end
    end
  end

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("error: %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_word(input string name, input logic [timer_pkg::DAT_W-1:0] exp,
                              input logic [timer_pkg::DAT_W-1:0] act);
    if (exp !== act) begin
      $display("error: %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  // Every output follows the model in every cycle after reset
  always @(negedge CLK_I) begin
    if (cycle != '0) begin
      compare_bit({test_name, " irq_o"}, |m_irq, irq_o);
      compare_bit({test_name, " RTY_O"}, |m_rty, RTY_O);
      compare_bit({test_name, " ACK_O"}, m_ack, ACK_O);
      compare_word({test_name, " DAT_O"}, m_ack ? status_word(m_pend) : '0, DAT_O);
    end
  end

  // Single classic cycle; exp_stat holds the pending lines seen at the sampling edge
  task automatic bus_access(input logic [timer_pkg::ADR_W-1:0] adr, input logic we,
                            input int max_wait, output logic [timer_pkg::DAT_W-1:0] data,
                            output logic acked, output logic retried,
                            output logic [timer_pkg::DAT_W-1:0] exp_stat);
    int n;
    @(negedge CLK_I);
    ADR_I    = adr;
    WE_I     = we;
    CYC_I    = 1'b1;
    STB_I    = 1'b1;
    exp_stat = status_word(m_irq);
    acked    = 1'b0;
    retried  = 1'b0;
    data     = '0;
    n        = 0;
    while (!acked && !retried && n < max_wait) begin
      @(negedge CLK_I);
      n       = n + 1;
      acked   = ACK_O;
      retried = RTY_O;
      data    = DAT_O;
    end
    CYC_I = 1'b0;
    STB_I = 1'b0;
    WE_I  = 1'b0;
  endtask

  task automatic read_status(output logic [timer_pkg::DAT_W-1:0] data);
    logic                        acked;
    logic                        retried;
    logic [timer_pkg::DAT_W-1:0] exp_stat;
    bus_access(timer_pkg::STAT_ADDR, 1'b0, 4, data, acked, retried, exp_stat);
    compare_bit({test_name, " status ACK"}, 1'b1, acked);
    compare_bit({test_name, " status RTY"}, 1'b0, retried);
    compare_word({test_name, " status word"}, exp_stat, data);
  endtask

  // Request stays up through the ACK cycle, as a registered master would leave it
  task automatic held_status_read();
    int replies;
    replies = 0;
    @(negedge CLK_I);
    ADR_I = timer_pkg::STAT_ADDR;
    WE_I  = 1'b0;
    CYC_I = 1'b1;
    STB_I = 1'b1;
    repeat (2) begin
      @(negedge CLK_I);
      if (ACK_O === 1'b1) begin
        replies = replies + 1;
      end
    end
    CYC_I = 1'b0;
    STB_I = 1'b0;
    compare_bit({test_name, " held read single ACK"}, 1'b1, replies == 1);
  endtask

  task automatic ack_timer(input logic [timer_pkg::ADR_W-1:0] adr,
                           output logic [timer_pkg::DAT_W-1:0] ack_cycle);
    logic [timer_pkg::DAT_W-1:0] data;
    logic                        acked;
    logic                        retried;
    logic [timer_pkg::DAT_W-1:0] exp_stat;
    bus_access(adr, 1'b0, 4, data, acked, retried, exp_stat);
    compare_bit({test_name, " acknowledge RTY"}, 1'b1, retried);
    compare_bit({test_name, " acknowledge ACK"}, 1'b0, acked);
    ack_cycle = cycle;
  endtask

  task automatic expect_no_reply(input logic [timer_pkg::ADR_W-1:0] adr, input logic we);
    logic [timer_pkg::DAT_W-1:0] data;
    logic                        acked;
    logic                        retried;
    logic [timer_pkg::DAT_W-1:0] exp_stat;
    bus_access(adr, we, 4, data, acked, retried, exp_stat);
    compare_bit({test_name, " unexpected RTY"}, 1'b0, retried);
    compare_bit({test_name, " unexpected ACK"}, 1'b0, acked);
  endtask

  task automatic wait_irq(input int max_cycles);
    int n;
    n = 0;
    while (irq_o !== 1'b1 && n < max_cycles) begin
      @(negedge CLK_I);
      n = n + 1;
    end
    if (irq_o !== 1'b1) begin
      $display("irq_o did not rise within %0d cycles during %s", max_cycles, test_name);
      abort_run();
    end
  endtask

  task automatic idle_gap();
    repeat ($urandom_range(20, 1)) @(negedge CLK_I);
  endtask

  task automatic test_reset_state();
    logic [timer_pkg::DAT_W-1:0] data;
    test_name = "reset_state";
    @(negedge CLK_I);
    compare_bit(test_name, 1'b0, ACK_O);
    compare_bit(test_name, 1'b0, RTY_O);
    compare_bit(test_name, 1'b0, irq_o);
    read_status(data);
    compare_word(test_name, '0, data);
    held_status_read();
  endtask

  task automatic test_timer1_fires();
    logic [timer_pkg::DAT_W-1:0] data;
    test_name = "timer1_fires";
    wait_irq(int'(timer_pkg::TERM1) + 100);
    compare_word({test_name, " cycle"}, count_word(timer_pkg::TERM1) + 32'd1, cycle);
    idle_gap();
    read_status(data);
    compare_word(test_name, status_word(2'b10), data);
  endtask

  task automatic test_ignored_requests();
    logic [timer_pkg::DAT_W-1:0] data;
    test_name = "ignored_requests";
    expect_no_reply(timer_pkg::ACK_ADDR0, 1'b0);
    read_status(data);
    compare_word(test_name, status_word(2'b10), data);
    expect_no_reply(timer_pkg::ACK_ADDR1, 1'b1);
    compare_bit(test_name, 1'b1, irq_o);
    read_status(data);
    compare_word(test_name, status_word(2'b10), data);
  endtask

  task automatic test_timer1_ack();
    logic [timer_pkg::DAT_W-1:0] data;
    logic [timer_pkg::DAT_W-1:0] ack_cycle;
    test_name = "timer1_ack";
    ack_timer(timer_pkg::ACK_ADDR1, ack_cycle);
    compare_bit(test_name, 1'b0, irq_o);
    read_status(data);
    compare_word(test_name, '0, data);
    wait_irq(int'(timer_pkg::TERM1) + 100);
    compare_word({test_name, " refire cycle"},
                 ack_cycle + count_word(timer_pkg::TERM1) + 32'd1, cycle);
  endtask

  // Timer 1 is serviced until timer 0 shows up in the status word
  task automatic test_timer0_and_status();
    logic [timer_pkg::DAT_W-1:0] data;
    logic [timer_pkg::DAT_W-1:0] ack_cycle;
    test_name = "timer0_and_status";
    data = '0;
    while (data[0] !== 1'b1) begin
      wait_irq(int'(timer_pkg::TERM1) + 100);
      idle_gap();
      read_status(data);
      if (data[0] !== 1'b1) begin
        compare_word(test_name, status_word(2'b10), data);
        idle_gap();
        ack_timer(timer_pkg::ACK_ADDR1, ack_cycle);
      end
    end
    idle_gap();
    ack_timer(timer_pkg::ACK_ADDR0, ack_cycle);
    read_status(data);
    compare_bit({test_name, " bit 0 cleared"}, 1'b0, data[0]);
    if (data[1]) begin
      ack_timer(timer_pkg::ACK_ADDR1, ack_cycle);
    end
  endtask

  initial begin
    void'($urandom(32'hc43a48bf));
    CLK_I     = 1'b0;
    RST_I     = 1'b1;
    ADR_I     = '0;
    CYC_I     = 1'b0;
    STB_I     = 1'b0;
    WE_I      = 1'b0;
    test_name = "reset";
    repeat (8) @(negedge CLK_I);
    RST_I = 1'b0;
    test_reset_state();
    test_timer1_fires();
    test_ignored_requests();
    test_timer1_ack();
    test_timer0_and_status();
    $display("RESULT: PASS");
    $finish;
  end

  // Four full timer 0 periods plus margin, in ns
  initial begin
    #((4 * (longint'(timer_pkg::TERM0) + 1) + 2000) * 100);
    $display("Simulation timed out before the tests finished");
    abort_run();
  end

endmodule

//--- hw/timer_subsys.sv
// Wishbone timer block top; single master, classic reads only, writes are ignored without reply
`timescale 1ns/1ns

module timer_subsys (
  input  logic                        CLK_I,
  input  logic                        RST_I,
  input  logic [31:2]                 ADR_I,
  input  logic                        CYC_I,
  input  logic                        STB_I,
  input  logic                        WE_I,
  output logic [timer_pkg::DAT_W-1:0] DAT_O,
  output logic                        ACK_O,
  output logic                        RTY_O,
  output logic                        irq_o
);

  logic [timer_pkg::N_TIMERS-1:0] irq;

  wb_if wb_t0 ();
  wb_if wb_t1 ();

  // Every timer sees the full request and decodes its own address
  assign wb_t0.adr = ADR_I;
  assign wb_t0.cyc = CYC_I;
  assign wb_t0.stb = STB_I;
  assign wb_t0.we  = WE_I;

  assign wb_t1.adr = ADR_I;
  assign wb_t1.cyc = CYC_I;
  assign wb_t1.stb = STB_I;
  assign wb_t1.we  = WE_I;

  timer #(
    .TERM     (timer_pkg::TERM0),
    .ACK_ADDR (timer_pkg::ACK_ADDR0)
  ) timer_0 (
    .CLK_I       (CLK_I),
    .RST_I       (RST_I),
    .bus         (wb_t0.slave),
    .interrupt_o (irq[0])
  );

  timer #(
    .TERM     (timer_pkg::TERM1),
    .ACK_ADDR (timer_pkg::ACK_ADDR1)
  ) timer_1 (
    .CLK_I       (CLK_I),
    .RST_I       (RST_I),
    .bus         (wb_t1.slave),
    .interrupt_o (irq[1])
  );

  // Status bit order follows the timer index
  irq_combiner irq_combiner (
    .CLK_I (CLK_I),
    .RST_I (RST_I),
    .t0    (wb_t0.monitor),
    .t1    (wb_t1.monitor),
    .irq_i (irq),
    .DAT_O (DAT_O),
    .ACK_O (ACK_O),
    .RTY_O (RTY_O),
    .irq_o (irq_o)
  );

endmodule

//--- hw/irq_combiner.sv
// Merges timer interrupts and RTY; status read gets ACK one cycle later, held requests get one ACK
`timescale 1ns/1ns

module irq_combiner (
  input  logic                           CLK_I,
  input  logic                           RST_I,
  wb_if.monitor                          t0,
  wb_if.monitor                          t1,
  input  logic [timer_pkg::N_TIMERS-1:0] irq_i,
  output logic [timer_pkg::DAT_W-1:0]    DAT_O,
  output logic                           ACK_O,
  output logic                           RTY_O,
  output logic                           irq_o
);

  logic                           stat_req;
  logic                           stat_take;
  logic [timer_pkg::N_TIMERS-1:0] pend;

  // Both bus views carry the same request, t0 is used for decode
  assign stat_req = t0.cyc && t0.stb && !t0.we && (t0.adr == timer_pkg::STAT_ADDR);

  // Skipping the cycle right after an ACK lets the master drop STB
  assign stat_take = stat_req && !ACK_O;

  always_ff @(posedge CLK_I) begin
    if (RST_I) begin
      ACK_O <= 1'b0;
    end else begin
      ACK_O <= stat_take;
    end
  end

  // Snapshot of the pending lines at the sampling edge
  always_ff @(posedge CLK_I) begin
    if (stat_take) begin
      pend <= irq_i;
    end
  end

  // Data lines stay quiet outside the ACK cycle
  assign DAT_O = ACK_O
               ? {{(timer_pkg::DAT_W - timer_pkg::N_TIMERS){1'b0}}, pend}
               : '0;

  // Only one acknowledge address can match, so at most one timer answers
  assign RTY_O = t0.rty || t1.rty;

  // Straight OR, no extra register in the interrupt path
  assign irq_o = |irq_i;

  // Overlapping RTY would mean the two timers decoded the same address
  assert property (@(posedge CLK_I) disable iff (RST_I) !(t0.rty && t1.rty));

endmodule

//--- hw/timer.sv
// Free-running terminal-count timer; only a read to ACK_ADDR with the interrupt pending restarts it
`timescale 1ns/1ns

module timer #(
  parameter logic [timer_pkg::CNT_W-1:0] TERM     = timer_pkg::TERM0,
  parameter logic [timer_pkg::ADR_W-1:0] ACK_ADDR = timer_pkg::ACK_ADDR0
) (
  input  logic CLK_I,
  input  logic RST_I,
  wb_if.slave  bus,
  output logic interrupt_o
);

  logic [timer_pkg::CNT_W-1:0] counter;
  logic                        rty;
  logic                        ack_req;
  logic                        at_term;
  logic                        ack_ok;

  // Read request aimed at this timer's acknowledge word
  assign ack_req = bus.cyc && bus.stb && !bus.we && (bus.adr == ACK_ADDR);
  assign at_term = (counter == TERM);

  // Accepted only once the interrupt is visible, so an early read is dropped
  assign ack_ok = ack_req && at_term && interrupt_o;

  always_ff @(posedge CLK_I) begin
    if (RST_I) begin
      counter     <= '0;
      interrupt_o <= 1'b0;
      rty         <= 1'b0;
    end else begin
      // RTY lasts one cycle since the interrupt is already low in that cycle
      rty <= ack_ok;
      if (ack_ok) begin
        counter     <= '0;
        interrupt_o <= 1'b0;
      end else if (at_term) begin
        // Counter saturates here and the interrupt becomes sticky
        interrupt_o <= 1'b1;
      end else begin
        counter <= counter + 1'b1;
      end
    end
  end

  assign bus.rty = rty;

  timer_assertions #(
    .TERM     (TERM),
    .ACK_ADDR (ACK_ADDR)
  ) u_chk (
    .CLK_I       (CLK_I),
    .RST_I       (RST_I),
    .ADR_I       (bus.adr),
    .CYC_I       (bus.cyc),
    .STB_I       (bus.stb),
    .WE_I        (bus.we),
    .RTY_O       (rty),
    .interrupt_o (interrupt_o),
    .counter     (counter)
  );

endmodule

//--- hw/timer_assertions.sv
// Checker for one timer; all rules are sampled on CLK_I and suspended while RST_I is high
`timescale 1ns/1ns

module timer_assertions #(
  parameter logic [timer_pkg::CNT_W-1:0] TERM     = timer_pkg::TERM0,
  parameter logic [timer_pkg::ADR_W-1:0] ACK_ADDR = timer_pkg::ACK_ADDR0
) (
  input logic                        CLK_I,
  input logic                        RST_I,
  input logic [timer_pkg::ADR_W-1:0] ADR_I,
  input logic                        CYC_I,
  input logic                        STB_I,
  input logic                        WE_I,
  input logic                        RTY_O,
  input logic                        interrupt_o,
  input logic [timer_pkg::CNT_W-1:0] counter
);

  logic req_hit;
  logic ack_cond;
  logic past_valid;

  assign req_hit  = CYC_I && STB_I && !WE_I && (ADR_I == ACK_ADDR);
  assign ack_cond = req_hit && (counter == TERM) && interrupt_o;

  // Set once a full cycle out of reset has been seen, so $past is meaningful
  always_ff @(posedge CLK_I) begin
    if (RST_I) begin
      past_valid <= 1'b0;
    end else begin
      past_valid <= 1'b1;
    end
  end

  default clocking cb @(posedge CLK_I);
  endclocking

  default disable iff (RST_I);

  // First cycle after reset shows the cleared state
  assert property ($past(RST_I) |-> (counter == '0) && !interrupt_o && !RTY_O);

  // Below the terminal value the count advances and nothing else moves
  assert property (past_valid && $past(counter != TERM)
                   |-> (counter == $past(counter) + 1'b1) && !RTY_O
                       && (interrupt_o == $past(interrupt_o)));

  // At the terminal value without an acknowledge the count holds and the interrupt is up
  assert property (past_valid && $past((counter == TERM) && !ack_cond)
                   |-> (counter == TERM) && interrupt_o && !RTY_O);

  // An accepted acknowledge pulses RTY and restarts from zero
  assert property (past_valid && $past(ack_cond)
                   |-> RTY_O && !interrupt_o && (counter == '0));

  // RTY has no other source
  assert property (RTY_O |-> past_valid && $past(ack_cond));

  // A pending interrupt survives everything except an acknowledge
  assert property (past_valid && $past(interrupt_o && !ack_cond)
                   |-> interrupt_o && (counter == TERM));

  cover property ($rose(interrupt_o));

  cover property (past_valid && $past(ack_cond) && RTY_O);

  // Read lands in the cycle the count first reaches TERM, before the interrupt is set
  cover property (past_valid && $past(req_hit && (counter == TERM) && !interrupt_o)
                  && interrupt_o && !RTY_O);

endmodule

//--- hw/wb_if.sv
// Wishbone classic single-read request plus RTY response; no data, SEL or ERR lines
`timescale 1ns/1ns

interface wb_if;

  logic [timer_pkg::ADR_W-1:0] adr;
  logic                        cyc;
  logic                        stb;
  logic                        we;
  logic                        rty;

  modport master (
    output adr,
    output cyc,
    output stb,
    output we,
    input  rty
  );

  modport slave (
    input  adr,
    input  cyc,
    input  stb,
    input  we,
    output rty
  );

  // Observes request and response without driving anything
  modport monitor (
    input adr,
    input cyc,
    input stb,
    input we,
    input rty
  );

endinterface

//--- hw/timer_pkg.sv
// Shared constants for the interval-timer block; addresses are word addresses (ADR_I[31:2])
package timer_pkg;

  // Counter width of every timer
  localparam int CNT_W = 28;

  // Word-address width, Wishbone ADR_I[31:2]
  localparam int ADR_W = 30;

  // Bus data width
  localparam int DAT_W = 32;

  // Number of timers behind the combiner
  localparam int N_TIMERS = 2;

  // Terminal counts. Timer 1 is short so it fires often
  localparam logic [CNT_W-1:0] TERM0 = 28'h00FFFFF;
  localparam logic [CNT_W-1:0] TERM1 = 28'h0000FFF;

  // All block registers live in the top word-address page
  localparam logic [ADR_W-4:0] ADDR_PAGE = 27'h7FFFFFF;

  // Status word, read only
  localparam logic [ADR_W-1:0] STAT_ADDR = {ADDR_PAGE, 3'b000};

  // Per-timer acknowledge addresses, answered with RTY
  localparam logic [ADR_W-1:0] ACK_ADDR0 = {ADDR_PAGE, 3'b001};
  localparam logic [ADR_W-1:0] ACK_ADDR1 = {ADDR_PAGE, 3'b010};

endpackage
